/* src/hisPkg.sv */
package hisPkg;

    // histogram geometry
    localparam int NB    = 64;                 // number of bins
    localparam int BIN_W = 6;                  // bits of a bin address

    typedef logic [BIN_W-1:0] binT;

    // raw time-to-digital stamp, upper bits select the coarse region
    localparam int STAMP_W = 10;

    typedef logic [STAMP_W-1:0] stampT;

    // per-bin event count
    localparam int COUNT_W = 16;

    typedef logic [COUNT_W-1:0] countT;

    localparam countT COUNT_MAX = '1;          // saturation level

    // acquisition phases
    typedef enum logic [1:0] {
        IDLE,       // waiting for start
        ACQUIRE,    // window open, hits are binned
        DRAIN,      // last decoded hit lands in memory
        READOUT     // bins are streamed out
    } acqStateT;

endpackage

/* src/binDecoder.sv */
`timescale 1ns/1ns

module binDecoder #(
    parameter logic [3:0] FINE_BASE = 4'd5
) (
    input  logic          clk,
    input  logic          res,
    input  logic          hit,
    input  hisPkg::stampT stamp,
    input  logic          acquiring,
    input  logic          fineMode,
    output logic          incStrobe,
    output hisPkg::binT   incBin
);
    import hisPkg::*;

    localparam int REGION_W = STAMP_W - BIN_W;

    binT                 coarseBin;
    binT                 fineBin;
    binT                 selBin;
    logic [REGION_W-1:0] region;
    logic                inRange;

    assign coarseBin = stamp[STAMP_W-1 -: BIN_W];   // upper six bits
    assign fineBin   = stamp[BIN_W-1:0];            // lower six bits
    assign region    = stamp[STAMP_W-1 -: REGION_W];

    // fine mode only keeps stamps from the zoomed coarse region
    assign inRange = !fineMode || (region == FINE_BASE);
    assign selBin  = fineMode ? fineBin : coarseBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            incStrobe <= 1'b0;
        end else begin
            incStrobe <= hit && acquiring && inRange;
        end
    end

    // bin address follows the stamp every cycle
    always_ff @(posedge clk) begin
        incBin <= selBin;
    end

    // an increment only ever stems from a hit inside the window
    property pStrobeInWindow;
        @(posedge clk) disable iff (!res)
        incStrobe |-> $past(acquiring);
    endproperty

    aStrobeInWindow: assert property (pStrobeInWindow)
        else $error("incStrobe without acquiring at the sampling edge");

endmodule

/* src/acqController.sv */
`timescale 1ns/1ns

module acqController #(
    parameter int ACQ_LEN = 200
) (
    input  logic clk,
    input  logic res,
    input  logic start,
    input  logic fine,
    input  logic readDone,
    output logic acquiring,
    output logic fineMode,
    output logic newFrame,
    output logic readStart
);
    import hisPkg::*;

    // window counter wide enough for ACQ_LEN-1
    localparam int CNT_W = (ACQ_LEN > 1) ? $clog2(ACQ_LEN) : 1;

    acqStateT         state;
    logic [CNT_W-1:0] winCnt;
    logic             winEnd;

    assign winEnd    = (winCnt == CNT_W'(ACQ_LEN - 1));
    assign acquiring = (state == ACQUIRE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            winCnt    <= '0;
            fineMode  <= 1'b0;
            newFrame  <= 1'b0;
            readStart <= 1'b0;
        end else begin
            newFrame  <= 1'b0;                  // single-cycle pulses
            readStart <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= ACQUIRE;
                        winCnt   <= '0;
                        fineMode <= fine;       // mode held for the whole frame
                        newFrame <= 1'b1;       // clears touched bits at next edge
                    end
                end
                ACQUIRE: begin
                    if (winEnd) begin
                        state     <= DRAIN;
                        readStart <= 1'b1;      // seen by readout as drain ends
                    end else begin
                        winCnt <= winCnt + 1'b1;
                    end
                end
                DRAIN: begin
                    state <= READOUT;
                end
                READOUT: begin
                    if (readDone) begin
                        state <= IDLE;          // start ignored until here
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    property pReadStartInDrain;
        @(posedge clk) disable iff (!res)
        readStart |-> (state == DRAIN);
    endproperty

    aReadStartInDrain: assert property (pReadStartInDrain)
        else $error("readStart outside the drain cycle");

endmodule

/* src/hisBuilderReg.sv */
`timescale 1ns/1ns

module hisBuilderReg (
    input  logic          clk,
    input  logic          res,
    input  logic          newFrame,
    input  logic          incStrobe,
    input  hisPkg::binT   incBin,
    input  hisPkg::binT   rdBin,
    output hisPkg::countT rdCount
);
    import hisPkg::*;

    countT         binMem [NB];     // count storage
    logic [NB-1:0] touched;         // bin written during this frame
    countT         curCount;
    countT         nextCount;

    // an untouched bin holds stale data from an older frame, treat it as 0
    assign curCount  = touched[incBin] ? binMem[incBin] : '0;
    assign nextCount = (curCount == COUNT_MAX) ? curCount : curCount + 1'b1;

    assign rdCount = touched[rdBin] ? binMem[rdBin] : '0;

    // read-modify-write completes in one cycle, so back-to-back hits stack
    always_ff @(posedge clk) begin
        if (incStrobe) begin
            binMem[incBin] <= nextCount;
        end
    end

    // lazy clear: whole frame is wiped by dropping the touched bits
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            touched <= '0;
        end else if (newFrame) begin
            touched <= '0;
        end else if (incStrobe) begin
            touched[incBin] <= 1'b1;
        end
    end

    // controller timing keeps the clear ahead of the first decoded hit
    property pClearNotWithInc;
        @(posedge clk) disable iff (!res)
        !(newFrame && incStrobe);
    endproperty

    aClearNotWithInc: assert property (pClearNotWithInc)
        else $error("newFrame collides with an increment");

endmodule

/* src/hisReadout.sv */
`timescale 1ns/1ns

module hisReadout (
    input  logic          clk,
    input  logic          res,
    input  logic          readStart,
    input  hisPkg::countT rdCount,
    output hisPkg::binT   rdBin,
    output hisPkg::binT   binOut,
    output hisPkg::countT countOut,
    output logic          binValid,
    output logic          peakValid,
    output logic          readDone,
    output hisPkg::binT   peakBin,
    output hisPkg::countT peakCount
);
    import hisPkg::*;

    logic scanning;
    binT  scanBin;
    logic lastBin;

    assign rdBin    = scanBin;                  // memory answers in the same cycle
    assign lastBin  = (scanBin == binT'(NB - 1));
    assign readDone = peakValid;                // controller leaves readout with the peak

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning  <= 1'b0;
            scanBin   <= '0;
            binValid  <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            binValid  <= scanning;
            peakValid <= binValid && (binOut == binT'(NB - 1));
            if (readStart && !scanning) begin
                scanning <= 1'b1;
                scanBin  <= '0;
            end else if (scanning) begin
                scanBin <= scanBin + 1'b1;      // wraps back to 0 after the last bin
                if (lastBin) begin
                    scanning <= 1'b0;
                end
            end
        end
    end

    // output stage and running maximum
    always_ff @(posedge clk) begin
        if (scanning) begin
            binOut   <= scanBin;
            countOut <= rdCount;
            // strictly greater, so the lower bin keeps a tie
            if (scanBin == '0 || rdCount > peakCount) begin
                peakBin   <= scanBin;
                peakCount <= rdCount;
            end
        end
    end

    // streamed bins form one unbroken ascending run
    property pBinStep;
        @(posedge clk) disable iff (!res)
        (binValid && $past(binValid)) |-> (binOut == binT'($past(binOut) + 1'b1));
    endproperty

    aBinStep: assert property (pBinStep)
        else $error("binOut did not step by one");

endmodule

/* src/hisBuilderTop.sv */
`timescale 1ns/1ns

module hisBuilderTop #(
    parameter int         ACQ_LEN   = 200,
    parameter logic [3:0] FINE_BASE = 4'd5
) (
    input  logic          clk,
    input  logic          res,
    input  logic          start,
    input  logic          fine,
    input  logic          hit,
    input  hisPkg::stampT stamp,
    output logic          acquiring,
    output logic          binValid,
    output hisPkg::binT   binOut,
    output hisPkg::countT countOut,
    output logic          peakValid,
    output hisPkg::binT   peakBin,
    output hisPkg::countT peakCount
);
    import hisPkg::*;

    logic  fineMode;
    logic  newFrame;
    logic  readStart;
    logic  readDone;
    logic  incStrobe;
    binT   incBin;
    binT   rdBin;
    countT rdCount;

    // window and phase sequencing
    acqController #(
        .ACQ_LEN   (ACQ_LEN)
    ) acqController_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .fine      (fine),
        .readDone  (readDone),
        .acquiring (acquiring),
        .fineMode  (fineMode),
        .newFrame  (newFrame),
        .readStart (readStart)
    );

    binDecoder #(
        .FINE_BASE (FINE_BASE)
    ) binDecoder_i (
        .clk       (clk),
        .res       (res),
        .hit       (hit),
        .stamp     (stamp),
        .acquiring (acquiring),
        .fineMode  (fineMode),
        .incStrobe (incStrobe),
        .incBin    (incBin)
    );

    // bin memory, written by the decoder and read by the readout
    hisBuilderReg hisBuilderReg_i (
        .clk       (clk),
        .res       (res),
        .newFrame  (newFrame),
        .incStrobe (incStrobe),
        .incBin    (incBin),
        .rdBin     (rdBin),
        .rdCount   (rdCount)
    );

    hisReadout hisReadout_i (
        .clk       (clk),
        .res       (res),
        .readStart (readStart),
        .rdCount   (rdCount),
        .rdBin     (rdBin),
        .binOut    (binOut),
        .countOut  (countOut),
        .binValid  (binValid),
        .peakValid (peakValid),
        .readDone  (readDone),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

endmodule

/* verification/tbHisBuilder.sv */
`timescale 1ns/1ns

module tbHisBuilder;
    import hisPkg::*;

    localparam int    CLK_PERIOD = 100;
    localparam int    TIMEOUT    = 1000;        // cycles allowed per wait loop
    localparam int    STIM_DEPTH = 256;
    localparam string STIM_FILE  = "verification/histInput.txt";

    logic  clk = 1'b0;
    logic  res;
    logic  start;
    logic  fine;
    logic  hit;
    stampT stamp;
    logic  acquiring;
    logic  binValid;
    binT   binOut;
    countT countOut;
    logic  peakValid;
    binT   peakBin;
    countT peakCount;

    integer      seed = 71;
    logic [31:0] stim [STIM_DEPTH];             // raw records from the data file
    stampT       stampQ [$];                    // stamps of the current frame
    countT       expCount [NB];
    logic        frameFine;
    binT         expPeakBin;
    countT       expPeakCount;

    hisBuilderTop #(
        .ACQ_LEN   (200),
        .FINE_BASE (4'd5)                       // fine records in the data file assume 5
    ) hisBuilderTop_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .fine      (fine),
        .hit       (hit),
        .stamp     (stamp),
        .acquiring (acquiring),
        .binValid  (binValid),
        .binOut    (binOut),
        .countOut  (countOut),
        .peakValid (peakValid),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkBin(input string name, input binT want, input binT got);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                               $time, name, want, got));
        end
    endtask

    task automatic checkCount(input string name, input countT want, input countT got);
        if (got !== want) begin
            abortRun($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                               $time, name, want, got));
        end
    endtask

    task automatic checkPeak(input binT wantBin, input countT wantCount,
                             input binT gotBin, input countT gotCount);
        checkBin("peakBin", wantBin, gotBin);
        checkCount("peakCount", wantCount, gotCount);
    endtask

    // random stamp on the bus with an optional hit
    task automatic driveNoise(input logic withHit);
        logic [31:0] rnd;
        rnd   = $random(seed);
        hit   = withHit & rnd[STAMP_W];
        stamp = rnd[STAMP_W-1:0];
    endtask

    task automatic waitAcquiring(input logic level);
        int cycles;
        cycles = 0;
        while (acquiring !== level) begin
            if (cycles == TIMEOUT) abortRun("timeout while waiting for acquiring");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic waitBinValid();
        int cycles;
        cycles = 0;
        while (binValid !== 1'b1) begin
            if (cycles == TIMEOUT) abortRun("timeout while waiting for binValid");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic runFrame(input int frameNo);
        int    gap;
        binT   ruleBin;
        countT ruleCount;
        // the peak record has to be the maximum where the lower bin wins a tie
        ruleBin   = '0;
        ruleCount = expCount[0];
        for (int b = 1; b < NB; b++) begin
            if (expCount[binT'(b)] > ruleCount) begin
                ruleBin   = binT'(b);
                ruleCount = expCount[binT'(b)];
            end
        end
        if (ruleBin !== expPeakBin || ruleCount !== expPeakCount) begin
            abortRun($sformatf("peak record of frame %0d does not match its bins", frameNo));
        end

        repeat (2) begin                        // controller stays idle under bus noise
            if (acquiring) abortRun("acquiring high while idle");
            driveNoise(1'b1);
            @(negedge clk);
        end
        hit   = 1'b0;
        start = 1'b1;
        fine  = frameFine;
        @(negedge clk);
        start = 1'b0;
        fine  = !frameFine;                     // mode has to stay latched
        waitAcquiring(1'b1);

        foreach (stampQ[i]) begin
            gap = {$random(seed)} % 3;
            repeat (gap) begin
                driveNoise(1'b0);
                @(negedge clk);
            end
            if (!acquiring) abortRun("window closed before all stamps were driven");
            hit   = 1'b1;
            stamp = stampQ[i];
            @(negedge clk);
        end
        hit = 1'b0;
        waitAcquiring(1'b0);

        driveNoise(1'b1);                       // hits in the drain cycle must not count
        waitBinValid();

        // stream check under bus noise and one stray start
        for (int i = 0; i < NB; i++) begin
            if (!binValid) abortRun("binValid dropped before the last bin");
            if (acquiring) abortRun("acquisition began during readout");
            checkBin("binOut", binT'(i), binOut);
            checkCount("countOut", expCount[binT'(i)], countOut);
            start = (i == 3);
            driveNoise(1'b1);
            @(negedge clk);
        end
        start = 1'b0;
        hit   = 1'b0;
        if (binValid) abortRun("binValid still high after the last bin");
        if (!peakValid) abortRun("peakValid missing in the cycle after the last bin");
        checkPeak(expPeakBin, expPeakCount, peakBin, peakCount);
        @(negedge clk);
        if (peakValid || acquiring) abortRun("controller did not settle in idle after the peak");
    endtask

    initial begin
        int         idx;
        int         frames;
        logic [3:0] tag;
        res   = 1'b0;
        start = 1'b0;
        fine  = 1'b0;
        hit   = 1'b0;
        stamp = '0;
        $readmemh(STIM_FILE, stim);
        repeat (2) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        if (acquiring || binValid || peakValid) abortRun("outputs not idle after reset");

        idx    = 0;
        frames = 0;
        while (stim[idx][31:28] !== 4'hF) begin
            tag = stim[idx][31:28];
            case (tag)
                4'h1: begin
                    frameFine = stim[idx][0];
                    stampQ.delete();
                    foreach (expCount[b]) expCount[b] = '0;
                end
                4'h2: stampQ.push_back(stim[idx][STAMP_W-1:0]);
                4'h3: expCount[stim[idx][16 +: BIN_W]] = stim[idx][COUNT_W-1:0];
                4'h4: begin                     // peak record closes a frame
                    expPeakBin   = stim[idx][16 +: BIN_W];
                    expPeakCount = stim[idx][COUNT_W-1:0];
                    frames++;
                    runFrame(frames);
                    $display("frame %0d checked", frames);
                end
                default: abortRun($sformatf("bad record %h at word %0d", stim[idx], idx));
            endcase
            idx++;
            if (idx == STIM_DEPTH) abortRun("stimulus file has no end record");
        end
        if (frames == 0) begin
            abortRun("stimulus file holds no frame");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* verification/histInput.txt */
// tag in top digit: 1 frame start (low digit 1 = fine), 2 timestamp in low 10 bits,
// 3 expected bin (bits 23:16) and count (15:0), 4 expected peak and run frame, F end

// frame 1, coarse, bins 10 and 18 tie at 3
10000000
20000123 2000012F 20000120 200003FF 20000000
200000A5 200000AF 200000A0 200002B1
30000001 300A0003 30120003 302B0001 303F0001
400A0003

// frame 2, fine around region 5, three stamps lie outside it
10000001
20000145 20000145 2000017F 20000140 20000185
20000105 200003C5 2000015A 2000015A 2000015A
30000001 30050002 301A0003 303F0001
401A0003

// frame 3, coarse, old counts of frame 2 must be gone
10000000
200003FF 200003F0 20000055
30050001 303F0002
403F0002

// frame 4, fine, nothing in range so all bins stay empty
10000001
20000000 200003FF 200001BF
40000000

F0000000

/* tb.f */
src/hisPkg.sv
src/binDecoder.sv
src/acqController.sv
src/hisBuilderReg.sv
src/hisReadout.sv
src/hisBuilderTop.sv
verification/tbHisBuilder.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbHisBuilder -f tb.f

out=$(./obj_dir/VtbHisBuilder) || true
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
